/* include/blksync_settings.svh */
// Block sync settings

`ifndef BLKSYNC_SETTINGS_SVH
`define BLKSYNC_SETTINGS_SVH

// coded block width, two header bits plus 64 payload bits
`define BLKSYNC_NB_BLOCK 66

// headers tested per window, while searching and while locked
`define BLKSYNC_SH_WINDOW 64

// invalid headers within one locked window that drop lock
`define BLKSYNC_INVALID_LIMIT 16

`endif

/* verilog/blksync_pkg.sv */
// Block sync types

`default_nettype none

`include "blksync_settings.svh"

package blksync_pkg;

    // lock search states
    typedef enum logic [2:0]
    {
        ST_LOCK_INIT = 3'd0,  // entered from reset or signal loss
        ST_RESET_CNT = 3'd1,  // clear header and invalid counts
        ST_TEST_SH   = 3'd2,  // unlocked, one header per word
        ST_SLIP      = 3'd3,  // move search offset by one bit
        ST_LOCKED    = 3'd4   // block boundary found
    } sync_state_t;

    // 64b/66b coded block, header first on the line
    // header 01 is a data block, 10 a control block, 00 and 11 are invalid
    typedef struct packed
    {
        logic [1:0]                    sh;
        logic [`BLKSYNC_NB_BLOCK-3:0]  payload;
    } coded_block_t;

endpackage

`default_nettype wire

/* verilog/serial_to_parallel.sv */
// Serial to parallel converter

`default_nettype none

`include "blksync_settings.svh"

module serial_to_parallel
(
    input  wire                          i_clock,
    input  wire                          i_rst_n,
    input  wire                          i_bit,
    input  wire                          i_bit_valid,
    output logic [`BLKSYNC_NB_BLOCK-1:0] o_word,        // bit 65 is the oldest bit
    output logic                         o_word_valid
);

    localparam int NB_BIT_CNT = $clog2(`BLKSYNC_NB_BLOCK);
    localparam logic [NB_BIT_CNT-1:0] LAST_BIT = NB_BIT_CNT'(`BLKSYNC_NB_BLOCK - 1);

    logic [`BLKSYNC_NB_BLOCK-1:0] shift_reg;
    logic [NB_BIT_CNT-1:0]        bit_cnt;

    // new bits enter at the bottom, so the first bit ends up on top
    always_ff @(posedge i_clock)
    begin
        if (i_bit_valid)
        begin
            shift_reg <= {shift_reg[`BLKSYNC_NB_BLOCK-2:0], i_bit};
        end
    end

    // word framing here is arbitrary, the block sync finds the boundary
    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            bit_cnt      <= '0;
            o_word_valid <= 1'b0;
        end
        else
        begin
            o_word_valid <= i_bit_valid && (bit_cnt == LAST_BIT);  // one cycle pulse
            if (i_bit_valid)
            begin
                if (bit_cnt == LAST_BIT)
                    bit_cnt <= '0;
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    assign o_word = shift_reg;

endmodule

`default_nettype wire

/* verilog/block_sync_fsm.sv */
// Block lock state machine

`default_nettype none

`include "blksync_settings.svh"

module block_sync_fsm
    import blksync_pkg::*;
(
    input  wire                                  i_clock,
    input  wire                                  i_rst_n,
    input  wire                                  i_word_valid,
    input  wire                                  i_signal_ok,
    input  wire                                  i_sh_valid,
    output logic [$clog2(`BLKSYNC_NB_BLOCK)-1:0] o_search_index,
    output logic [$clog2(`BLKSYNC_NB_BLOCK)-1:0] o_block_index,
    output logic                                 o_block_lock
);

    localparam int NB_INDEX   = $clog2(`BLKSYNC_NB_BLOCK);
    localparam int NB_SH_CNT  = $clog2(`BLKSYNC_SH_WINDOW + 1);
    localparam int NB_INV_CNT = $clog2(`BLKSYNC_INVALID_LIMIT + 1);

    localparam logic [NB_INDEX-1:0]   LAST_INDEX = NB_INDEX'(`BLKSYNC_NB_BLOCK - 1);
    localparam logic [NB_SH_CNT-1:0]  SH_WINDOW  = NB_SH_CNT'(`BLKSYNC_SH_WINDOW);
    localparam logic [NB_INV_CNT-1:0] INV_LIMIT  = NB_INV_CNT'(`BLKSYNC_INVALID_LIMIT);

    sync_state_t           state;
    logic [NB_SH_CNT-1:0]  sh_cnt;       // headers seen in this window
    logic [NB_INV_CNT-1:0] inv_cnt;      // invalid headers in this window
    logic [NB_SH_CNT-1:0]  sh_cnt_inc;
    logic [NB_INV_CNT-1:0] inv_cnt_inc;
    logic                  window_done;
    logic                  inv_limit_hit;

    // counts including the header under test
    assign sh_cnt_inc    = sh_cnt + 1'b1;
    assign inv_cnt_inc   = inv_cnt + NB_INV_CNT'(!i_sh_valid);
    assign window_done   = (sh_cnt_inc == SH_WINDOW);
    assign inv_limit_hit = (inv_cnt_inc == INV_LIMIT);

    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            state          <= ST_LOCK_INIT;
            o_search_index <= '0;
            o_block_index  <= '0;
            sh_cnt         <= '0;
            inv_cnt        <= '0;
            o_block_lock   <= 1'b0;
        end
        else if (!i_signal_ok)
        begin
            state        <= ST_LOCK_INIT;  // offsets are kept, search resumes there
            o_block_lock <= 1'b0;
        end
        else
        begin
            case (state)
                ST_LOCK_INIT:
                begin
                    o_block_lock <= 1'b0;
                    state        <= ST_RESET_CNT;
                end
                ST_RESET_CNT:
                begin
                    sh_cnt  <= '0;
                    inv_cnt <= '0;
                    state   <= ST_TEST_SH;
                end
                ST_TEST_SH:
                begin
                    // while searching a single bad header means wrong offset
                    if (i_word_valid)
                    begin
                        if (!i_sh_valid)
                        begin
                            state <= ST_SLIP;
                        end
                        else if (window_done)
                        begin
                            o_block_lock  <= 1'b1;
                            o_block_index <= o_search_index;
                            sh_cnt        <= '0;
                            inv_cnt       <= '0;
                            state         <= ST_LOCKED;
                        end
                        else
                        begin
                            sh_cnt <= sh_cnt_inc;
                        end
                    end
                end
                ST_SLIP:
                begin
                    if (o_search_index == LAST_INDEX)
                        o_search_index <= '0;
                    else
                        o_search_index <= o_search_index + 1'b1;
                    state <= ST_RESET_CNT;
                end
                ST_LOCKED:
                begin
                    if (i_word_valid)
                    begin
                        if (inv_limit_hit)
                        begin
                            o_block_lock <= 1'b0;  // too many errors, look elsewhere
                            state        <= ST_SLIP;
                        end
                        else if (window_done)
                        begin
                            sh_cnt  <= '0;         // fresh window
                            inv_cnt <= '0;
                        end
                        else
                        begin
                            sh_cnt  <= sh_cnt_inc;
                            inv_cnt <= inv_cnt_inc;
                        end
                    end
                end
                default:
                begin
                    state <= ST_LOCK_INIT;
                end
            endcase
        end
    end

    // lock flag and state register must agree on every edge
    a_lock_in_locked: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_block_lock |-> (state == ST_LOCKED));

    a_search_range: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_search_index <= LAST_INDEX);

endmodule

`default_nettype wire

/* verilog/block_sync_module.sv */
// Block synchronizer

`default_nettype none

`include "blksync_settings.svh"

module block_sync_module
    import blksync_pkg::*;
(
    input  wire                          i_clock,
    input  wire                          i_rst_n,
    input  wire [`BLKSYNC_NB_BLOCK-1:0]  i_word,
    input  wire                          i_word_valid,
    input  wire                          i_signal_ok,
    output coded_block_t                 o_block,
    output logic                         o_block_valid,
    output logic                         o_block_lock
);

    localparam int NB_INDEX  = $clog2(`BLKSYNC_NB_BLOCK);
    localparam int NB_WINDOW = 2 * `BLKSYNC_NB_BLOCK;

    logic [`BLKSYNC_NB_BLOCK-1:0] word_prev;
    logic [NB_WINDOW-1:0]         window;      // previous word on top
    logic [NB_INDEX-1:0]          search_index;
    logic [NB_INDEX-1:0]          block_index;
    logic                         sh_valid;

    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n || !i_signal_ok)
            word_prev <= '0;
        else if (i_word_valid)
            word_prev <= i_word;
    end

    assign window = {word_prev, i_word};

    // offsets count from the oldest bit of the window
    assign sh_valid = ^window[(NB_WINDOW - 1 - search_index) -: 2];  // 01 or 10

    assign o_block       = coded_block_t'(window[(NB_WINDOW - 1 - block_index) -: `BLKSYNC_NB_BLOCK]);
    assign o_block_valid = i_word_valid;

    block_sync_fsm u_block_sync_fsm
    (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_word_valid   (i_word_valid),
        .i_signal_ok    (i_signal_ok),
        .i_sh_valid     (sh_valid),
        .o_search_index (search_index),
        .o_block_index  (block_index),
        .o_block_lock   (o_block_lock)
    );

    // extraction must stay inside the 132-bit window
    a_block_index_range: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        block_index <= NB_INDEX'(`BLKSYNC_NB_BLOCK - 1));

endmodule

`default_nettype wire

/* verilog/descrambler_64b.sv */
// 64b/66b payload descrambler

`default_nettype none

`include "blksync_settings.svh"

module descrambler_64b
    import blksync_pkg::*;
(
    input  wire          i_clock,
    input  wire          i_rst_n,
    input  wire          i_block_valid,
    input  coded_block_t i_block,
    output coded_block_t o_block,
    output logic         o_block_valid
);

    localparam int NB_PAYLOAD = `BLKSYNC_NB_BLOCK - 2;
    localparam int NB_STATE   = 58;  // x^58 + x^39 + 1
    localparam int TAP_NEAR   = 38;
    localparam int TAP_FAR    = 57;

    logic [NB_STATE-1:0]   scr_state;   // bit 0 holds the newest received bit
    logic [NB_STATE-1:0]   state_next;
    logic [NB_PAYLOAD-1:0] payload_next;

    // self-synchronizing, the state is fed with scrambled bits
    always_comb
    begin
        state_next = scr_state;
        for (int i = NB_PAYLOAD - 1; i >= 0; i--)
        begin
            payload_next[i] = i_block.payload[i] ^ state_next[TAP_NEAR] ^ state_next[TAP_FAR];
            state_next      = {state_next[NB_STATE-2:0], i_block.payload[i]};
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            scr_state     <= '0;
            o_block_valid <= 1'b0;
        end
        else
        begin
            o_block_valid <= i_block_valid;
            if (i_block_valid)
                scr_state <= state_next;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_block_valid)
        begin
            o_block.sh      <= i_block.sh;  // header is never scrambled
            o_block.payload <= payload_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/pcs_rx_sync_top.sv */
// PCS receive block sync top

`default_nettype none

`include "blksync_settings.svh"

module pcs_rx_sync_top
    import blksync_pkg::*;
(
    input  wire          i_clock,
    input  wire          i_rst_n,
    input  wire          i_bit,
    input  wire          i_bit_valid,
    input  wire          i_signal_ok,
    output coded_block_t o_block,
    output logic         o_block_valid,
    output logic         o_block_lock
);

    wire [`BLKSYNC_NB_BLOCK-1:0] word;
    wire                         word_valid;
    coded_block_t                sync_block;
    wire                         sync_block_valid;
    wire                         desc_valid;

    // only aligned blocks reach the descrambler
    assign desc_valid = sync_block_valid & o_block_lock;

    serial_to_parallel u_serial_to_parallel
    (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_bit        (i_bit),
        .i_bit_valid  (i_bit_valid),
        .o_word       (word),
        .o_word_valid (word_valid)
    );

    block_sync_module u_block_sync_module
    (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_word        (word),
        .i_word_valid  (word_valid),
        .i_signal_ok   (i_signal_ok),
        .o_block       (sync_block),
        .o_block_valid (sync_block_valid),
        .o_block_lock  (o_block_lock)
    );

    descrambler_64b u_descrambler_64b
    (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_block_valid (desc_valid),
        .i_block       (sync_block),
        .o_block       (o_block),
        .o_block_valid (o_block_valid)
    );

endmodule

`default_nettype wire

/* verif/tb_pcs_rx_sync.sv */
// PCS receive block sync testbench

`default_nettype none

module tb_pcs_rx_sync
    import blksync_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam realtime HALF_PERIOD = 20ns;
    localparam realtime PERIOD      = 40ns;
    localparam string   TRACE_FILE  = "verif/pcs_rx_sync_trace.txt";
    localparam int      MAX_RECORDS = 32;
    localparam int      SEED        = 56;

    logic         i_clock;
    logic         i_rst_n;
    logic         i_bit;
    logic         i_bit_valid;
    logic         i_signal_ok;
    coded_block_t o_block;
    logic         o_block_valid;
    logic         o_block_lock;

    // trace records
    int          rec_repeat [MAX_RECORDS];
    logic [65:0] rec_block  [MAX_RECORDS];
    int          rec_err    [MAX_RECORDS];
    int          rec_sok    [MAX_RECORDS];
    int          rec_lock   [MAX_RECORDS];   // -1 is don't care
    logic [63:0] rec_pay    [MAX_RECORDS];
    bit          rec_pay_ok [MAX_RECORDS];
    int          num_records;

    // expected output per sent block, with the time its last bit went out
    realtime     exp_time    [$];
    logic [1:0]  exp_sh      [$];
    logic [63:0] exp_payload [$];
    bit          exp_known   [$];

    int          check_errors;
    int          other_errors;
    int          outputs_seen;   // output blocks so far
    longint      cycles;
    longint      cycle_limit;

    pcs_rx_sync_top u_dut
    (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_bit         (i_bit),
        .i_bit_valid   (i_bit_valid),
        .i_signal_ok   (i_signal_ok),
        .o_block       (o_block),
        .o_block_valid (o_block_valid),
        .o_block_lock  (o_block_lock)
    );

    always #(HALF_PERIOD) i_clock = ~i_clock;

    task automatic load_trace();
        int    fd;
        int    n;
        int    rep;
        int    err;
        int    sok;
        string line;
        string lock_s;
        string pay_s;
        logic [65:0] blk;
        logic [63:0] pay;
        fd = $fopen(TRACE_FILE, "r");
        num_records = 0;
        if (fd == 0)
        begin
            $display("cannot open trace file %s", TRACE_FILE);
            other_errors++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            n = $sscanf(line, "%d %h %d %d %s %s", rep, blk, err, sok, lock_s, pay_s);
            if (n != 6 || num_records == MAX_RECORDS)
            begin
                $display("malformed or excess trace line: %s", line);
                other_errors++;
                continue;
            end
            rec_repeat[num_records] = rep;
            rec_block[num_records]  = blk;
            rec_err[num_records]    = err;
            rec_sok[num_records]    = sok;
            rec_lock[num_records]   = (lock_s == "x") ? -1 : lock_s.atoi();
            rec_pay_ok[num_records] = (pay_s != "x");
            pay = '0;
            if (pay_s != "x")
                void'($sscanf(pay_s, "%h", pay));
            rec_pay[num_records] = pay;
            num_records++;
        end
        $fclose(fd);
    endtask

    // one bit per clock, first bit is the header msb
    task automatic send_block(input logic [65:0] blk, input int sok);
        for (int b = 65; b >= 0; b--)
        begin
            @(posedge i_clock);
            i_bit       <= blk[b];
            i_bit_valid <= 1'b1;
            i_signal_ok <= sok[0];
        end
    endtask

    // outputs settle by the falling edge
    always @(negedge i_clock)
    begin
        if (i_rst_n && o_block_valid)
        begin
            outputs_seen <= outputs_seen + 1;
            while (exp_time.size() >= 2 && exp_time[1] + 2 * PERIOD <= $realtime)
            begin
                void'(exp_time.pop_front());
                void'(exp_sh.pop_front());
                void'(exp_payload.pop_front());
                void'(exp_known.pop_front());
            end
            if (exp_time.size() == 0)
            begin
                $display("output block seen before any block was sent");
                other_errors++;
            end
            else
            begin
                if (o_block.sh != exp_sh[0])
                begin
                    $display("CHECK FAILED at %0t: header %b, expected %b",
                             $realtime, o_block.sh, exp_sh[0]);
                    check_errors++;
                end
                if (exp_known[0] && o_block.payload != exp_payload[0])
                begin
                    $display("CHECK FAILED at %0t: payload %h, expected %h",
                             $realtime, o_block.payload, exp_payload[0]);
                    check_errors++;
                end
            end
        end
    end

    always @(posedge i_clock)
    begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    initial
    begin
        int          lead;
        int          sent;
        int          prev_outputs;
        logic [65:0] blk;
        logic [63:0] pay;
        i_clock      = 1'b0;
        i_rst_n      = 1'b0;
        i_bit        = 1'b0;
        i_bit_valid  = 1'b0;
        i_signal_ok  = 1'b1;
        check_errors = 0;
        other_errors = 0;
        outputs_seen = 0;
        prev_outputs = 0;
        cycles       = 0;
        cycle_limit  = 64'd1000000000;
        sent         = 0;
        void'($urandom(SEED));

        load_trace();
        cycle_limit = 1000 + 65 + 4;  // leading bits and reset
        for (int r = 0; r < num_records; r++)
            cycle_limit += longint'(rec_repeat[r]) * 66;

        repeat (4) @(posedge i_clock);
        i_rst_n <= 1'b1;

        // random block boundary
        lead = 1 + ($urandom % 65);
        for (int k = 0; k < lead; k++)
        begin
            @(posedge i_clock);
            i_bit       <= 1'($urandom & 1);
            i_bit_valid <= 1'b1;
        end

        for (int r = 0; r < num_records; r++)
        begin
            for (int n = 0; n < rec_repeat[r]; n++)
            begin
                blk = rec_block[r];
                pay = rec_pay[r];
                if (rec_err[r] != 0)
                    blk[65:64] = 2'b00;
                if (sent % 2 == 1)
                begin
                    blk[63:0] = ~blk[63:0];  // keeps every wrong offset invalid
                    pay       = ~pay;
                end
                send_block(blk, rec_sok[r]);
                exp_time.push_back($realtime);
                exp_sh.push_back(blk[65:64]);
                exp_payload.push_back(pay);
                exp_known.push_back(rec_pay_ok[r]);
                sent++;
            end
            @(negedge i_clock);
            if (rec_lock[r] >= 0 && o_block_lock != rec_lock[r][0])
            begin
                $display("CHECK FAILED at %0t: record %0d lock %b, expected %0d",
                         $realtime, r, o_block_lock, rec_lock[r]);
                check_errors++;
            end
            // lock high at both ends of a record, so one output per block sent
            if (r > 0 && rec_lock[r] == 1 && rec_lock[r-1] == 1
                && outputs_seen - prev_outputs != rec_repeat[r])
            begin
                $display("CHECK FAILED at %0t: record %0d gave %0d blocks, expected %0d",
                         $realtime, r, outputs_seen - prev_outputs, rec_repeat[r]);
                check_errors++;
            end
            prev_outputs = outputs_seen;
        end

        repeat (4) @(posedge i_clock);
        $display("errors: %0d check failures, %0d other", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0 && num_records > 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
verilog/blksync_pkg.sv
verilog/serial_to_parallel.sv
verilog/block_sync_fsm.sv
verilog/block_sync_module.sv
verilog/descrambler_64b.sv
verilog/pcs_rx_sync_top.sv
verif/tb_pcs_rx_sync.sv

/* Makefile */
# Verilator build and run for the PCS receive block sync

VERILATOR ?= verilator
TOP       ?= tb_pcs_rx_sync
RTL_TOP   ?= pcs_rx_sync_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Everything OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/pcs_rx_sync_trace.txt */
# repeat  block(66b hex)  err(1=header 00)  signal_ok  lock(1/0/x)  payload(hex or x)
# blocks with an odd running number go out with the payload inverted, expected payload too
4288 10000000000000000 0 1 1 x
20   10000000000000000 0 1 1 00000000001ffffc0
15   10000000000000000 1 1 1 00000000001ffffc0
60   10000000000000000 0 1 1 00000000001ffffc0
36   10000000000000000 1 1 0 00000000001ffffc0
4288 10000000000000000 0 1 1 x
20   10000000000000000 0 1 1 00000000001ffffc0
4    10000000000000000 0 0 0 x
4288 10000000000000000 0 1 1 x
20   10000000000000000 0 1 1 00000000001ffffc0
